// ==== bit_core.f ====
hdl/bit_core_pkg.sv
hdl/line_ram.sv
hdl/fetch_unit.sv
hdl/inst_decoder.sv
hdl/reg_file.sv
hdl/bmu.sv
hdl/bit_core.sv
tests/bit_core_props.sv
tests/bit_core_tb.sv

// ==== hdl/bit_core.sv ====
module bit_core (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  load_valid,
   input  bit_core_pkg::load_s   load,
   input  logic                  run,
   output logic                  retire_valid,
   output bit_core_pkg::retire_s retire,
   output logic                  halted
);

   logic [bit_core_pkg::line_addr_w-1:0] rd_addr;
   logic [bit_core_pkg::line_w-1:0]      rd_line;
   bit_core_pkg::inst_u                  inst;
   bit_core_pkg::dec_s                   dec;
   logic [bit_core_pkg::xlen-1:0]        pc;
   logic [bit_core_pkg::xlen-1:0]        next_pc;
   logic [bit_core_pkg::xlen-1:0]        rs1_data;
   logic [bit_core_pkg::xlen-1:0]        rs2_data;
   logic [bit_core_pkg::xlen-1:0]        result;
   logic                                 inst_valid;
   logic                                 reg_we;

   // program lines only go in while stopped
   line_ram u_line_ram (
      .clk        (clk),
      .load_valid (load_valid && !run),
      .load       (load),
      .rd_addr    (rd_addr),
      .rd_line    (rd_line)
   );

   fetch_unit u_fetch_unit (
      .clk        (clk),
      .reset      (reset),
      .run        (run),
      .next_pc    (next_pc),
      .advance    (inst_valid),
      .rd_addr    (rd_addr),
      .rd_line    (rd_line),
      .inst       (inst),
      .pc         (pc),
      .inst_valid (inst_valid),
      .halted     (halted)
   );

   inst_decoder u_inst_decoder (
      .inst (inst),
      .dec  (dec)
   );

   assign reg_we = inst_valid && dec.writes_rd;

   reg_file u_reg_file (
      .clk      (clk),
      .reset    (reset),
      .rs1      (dec.rs1),
      .rs2      (dec.rs2),
      .rs1_data (rs1_data),
      .rs2_data (rs2_data),
      .we       (reg_we),
      .rd       (dec.rd),
      .rd_data  (result)
   );

   bmu u_bmu (
      .dec      (dec),
      .rs1_data (rs1_data),
      .rs2_data (rs2_data),
      .pc       (pc),
      .result   (result),
      .next_pc  (next_pc)
   );

   // one retire per executed word; x0 and illegal words report zero
   assign retire_valid = inst_valid;
   assign retire.pc    = pc;
   assign retire.rd    = dec.writes_rd ? dec.rd : 5'd0;
   assign retire.value = (dec.writes_rd && dec.rd != 5'd0) ? result : '0;

endmodule

// ==== hdl/bit_core_pkg.sv ====
package bit_core_pkg;

   // data and memory geometry
   localparam int xlen        = 32;
   localparam int line_words  = 4;
   localparam int ram_lines   = 64;
   localparam int line_addr_w = 6;
   localparam int line_w      = line_words * xlen;

   // major opcodes
   localparam logic [6:0] op_imm = 7'b0010011;
   localparam logic [6:0] op_reg = 7'b0110011;
   localparam logic [6:0] op_lui = 7'b0110111;
   localparam logic [6:0] op_jal = 7'b1101111;

   // funct7 groups, base and Zba/Zbb/Zbs
   localparam logic [6:0] f7_base = 7'b0000000;
   localparam logic [6:0] f7_alt  = 7'b0100000;
   localparam logic [6:0] f7_zba  = 7'b0010000;
   localparam logic [6:0] f7_rot  = 7'b0110000;
   localparam logic [6:0] f7_zext = 7'b0000100;
   localparam logic [6:0] f7_bclr = 7'b0100100;
   localparam logic [6:0] f7_binv = 7'b0110100;
   localparam logic [6:0] f7_bset = 7'b0010100;

   // full imm12 of the fixed-pattern unary ops
   localparam logic [11:0] imm12_orc_b = 12'h287;
   localparam logic [11:0] imm12_rev8  = 12'h698;

   typedef enum logic [5:0] {
      op_nop, op_addi, op_xori, op_andi, op_ori, op_load_upper,
      op_add, op_sub, op_xor, op_or, op_and, op_jump,
      op_sh1add, op_sh2add, op_sh3add, op_andn, op_orn, op_xnor,
      op_clz, op_ctz, op_cpop, op_sext_b, op_sext_h, op_zext_h, op_rev8, op_orc_b,
      op_rol, op_ror, op_rori, op_bclr, op_bclri, op_bext, op_bexti,
      op_binv, op_binvi, op_bset, op_bseti
   } bmu_op_e;

   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } r_fmt_s;

   typedef struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } i_fmt_s;

   // one instruction word, two field layouts
   typedef union packed {
      r_fmt_s r_fmt;
      i_fmt_s i_fmt;
   } inst_u;

   typedef struct packed {
      bmu_op_e          op;
      logic [4:0]       rd;
      logic [4:0]       rs1;
      logic [4:0]       rs2;
      logic [xlen-1:0]  imm;
      logic             use_imm;
      logic             writes_rd;
      logic             illegal;
   } dec_s;

   typedef struct packed {
      logic [xlen-1:0] pc;
      logic [4:0]      rd;
      logic [xlen-1:0] value;
   } retire_s;

   typedef struct packed {
      logic [line_addr_w-1:0] addr;
      logic [line_w-1:0]      line;
   } load_s;

endpackage

// ==== hdl/bmu.sv ====
module bmu (
   input  bit_core_pkg::dec_s            dec,
   input  logic [bit_core_pkg::xlen-1:0] rs1_data,
   input  logic [bit_core_pkg::xlen-1:0] rs2_data,
   input  logic [bit_core_pkg::xlen-1:0] pc,
   output logic [bit_core_pkg::xlen-1:0] result,
   output logic [bit_core_pkg::xlen-1:0] next_pc
);

   logic [31:0] a;
   logic [31:0] b;
   logic [4:0]  sh;
   logic [63:0] dbl;
   logic [31:0] bit_mask;
   logic [31:0] rot_left;
   logic [31:0] rot_right;
   logic [31:0] orc;
   logic [31:0] pc_plus4;

   // leading zeros, 32 for a zero word
   function automatic logic [5:0] count_lz(input logic [31:0] v);
      logic [5:0] n;
      logic       found;
      n     = '0;
      found = 1'b0;
      for (int i = 31; i >= 0; i--) begin
         if (v[i]) found = 1'b1;
         else if (!found) n = n + 6'd1;
      end
      return n;
   endfunction

   // trailing zeros, same rule at zero
   function automatic logic [5:0] count_tz(input logic [31:0] v);
      logic [5:0] n;
      logic       found;
      n     = '0;
      found = 1'b0;
      for (int i = 0; i < 32; i++) begin
         if (v[i]) found = 1'b1;
         else if (!found) n = n + 6'd1;
      end
      return n;
   endfunction

   function automatic logic [5:0] count_ones(input logic [31:0] v);
      logic [5:0] n;
      n = '0;
      for (int i = 0; i < 32; i++) begin
         n = n + {5'd0, v[i]};
      end
      return n;
   endfunction

   assign a  = rs1_data;
   // immediate forms take imm as the second operand
   assign b  = dec.use_imm ? dec.imm : rs2_data;
   assign sh = b[4:0];

   // rotates through a doubled word
   assign dbl       = {a, a};
   assign rot_right = 32'(dbl >> sh);
   assign rot_left  = dbl[63:32] << sh | dbl[31:0] >> (6'd32 - {1'b0, sh});
   assign bit_mask  = 32'd1 << sh;
   assign pc_plus4  = pc + 32'd4;

   // per byte, ff when any bit set
   always_comb begin
      for (int i = 0; i < 4; i++) begin
         orc[i*8 +: 8] = (|a[i*8 +: 8]) ? 8'hff : 8'h00;
      end
   end

   always_comb begin
      result  = '0;
      next_pc = pc_plus4;
      case (dec.op)
         bit_core_pkg::op_addi,
         bit_core_pkg::op_add:        result = a + b;
         bit_core_pkg::op_sub:        result = a - b;
         bit_core_pkg::op_xori,
         bit_core_pkg::op_xor:        result = a ^ b;
         bit_core_pkg::op_andi,
         bit_core_pkg::op_and:        result = a & b;
         bit_core_pkg::op_ori,
         bit_core_pkg::op_or:         result = a | b;
         bit_core_pkg::op_load_upper: result = dec.imm;
         bit_core_pkg::op_jump: begin
            // link value, target is pc relative
            result  = pc_plus4;
            next_pc = pc + dec.imm;
         end
         bit_core_pkg::op_sh1add:     result = (a << 1) + b;
         bit_core_pkg::op_sh2add:     result = (a << 2) + b;
         bit_core_pkg::op_sh3add:     result = (a << 3) + b;
         bit_core_pkg::op_andn:       result = a & ~b;
         bit_core_pkg::op_orn:        result = a | ~b;
         bit_core_pkg::op_xnor:       result = ~(a ^ b);
         bit_core_pkg::op_clz:        result = {26'd0, count_lz(a)};
         bit_core_pkg::op_ctz:        result = {26'd0, count_tz(a)};
         bit_core_pkg::op_cpop:       result = {26'd0, count_ones(a)};
         bit_core_pkg::op_sext_b:     result = {{24{a[7]}}, a[7:0]};
         bit_core_pkg::op_sext_h:     result = {{16{a[15]}}, a[15:0]};
         bit_core_pkg::op_zext_h:     result = {16'd0, a[15:0]};
         bit_core_pkg::op_rev8:       result = {a[7:0], a[15:8], a[23:16], a[31:24]};
         bit_core_pkg::op_orc_b:      result = orc;
         bit_core_pkg::op_rol:        result = rot_left;
         bit_core_pkg::op_ror,
         bit_core_pkg::op_rori:       result = rot_right;
         bit_core_pkg::op_bclr,
         bit_core_pkg::op_bclri:      result = a & ~bit_mask;
         bit_core_pkg::op_bext,
         bit_core_pkg::op_bexti:      result = {31'd0, a[sh]};
         bit_core_pkg::op_binv,
         bit_core_pkg::op_binvi:      result = a ^ bit_mask;
         bit_core_pkg::op_bset,
         bit_core_pkg::op_bseti:      result = a | bit_mask;
         default:                     result = '0;
      endcase
   end

endmodule

// ==== hdl/fetch_unit.sv ====
module fetch_unit (
   input  logic                                 clk,
   input  logic                                 reset,
   input  logic                                 run,
   input  logic [bit_core_pkg::xlen-1:0]        next_pc,
   input  logic                                 advance,
   output logic [bit_core_pkg::line_addr_w-1:0] rd_addr,
   input  logic [bit_core_pkg::line_w-1:0]      rd_line,
   output bit_core_pkg::inst_u                  inst,
   output logic [bit_core_pkg::xlen-1:0]        pc,
   output logic                                 inst_valid,
   output logic                                 halted
);

   // high in the execute half of an instruction
   logic execute;

   // 16-byte lines, so the line index starts at pc bit 4
   assign rd_addr = pc[bit_core_pkg::line_addr_w+3:4];

   // word 0 sits in the low 32 bits of the line
   assign inst = rd_line[pc[3:2]*bit_core_pkg::xlen +: bit_core_pkg::xlen];

   assign inst_valid = execute;

   always_ff @(posedge clk) begin
      if (reset) begin
         pc      <= '0;
         execute <= 1'b0;
         halted  <= 1'b0;
      end else if (execute) begin
         // execute phase always completes, back to request
         execute <= 1'b0;
         if (advance) begin
            pc <= next_pc;
            // jump to itself means stop
            if (next_pc == pc) begin
               halted <= 1'b1;
            end
         end
      end else if (run && !halted) begin
         // request phase, line read is in flight
         execute <= 1'b1;
      end
   end

endmodule

// ==== hdl/inst_decoder.sv ====
module inst_decoder (
   input  bit_core_pkg::inst_u inst,
   output bit_core_pkg::dec_s  dec
);

   logic [31:0] word;
   logic [6:0]  f7;
   logic [2:0]  f3;
   logic [4:0]  shamt;

   assign word  = inst;
   assign f7    = inst.r_fmt.funct7;
   assign f3    = inst.r_fmt.funct3;
   // shift-immediate forms carry the amount in the rs2 slot
   assign shamt = inst.r_fmt.rs2;

   always_comb begin
      dec.op        = bit_core_pkg::op_nop;
      dec.rd        = inst.r_fmt.rd;
      dec.rs1       = inst.r_fmt.rs1;
      dec.rs2       = inst.r_fmt.rs2;
      dec.imm       = {{20{inst.i_fmt.imm12[11]}}, inst.i_fmt.imm12};
      dec.use_imm   = 1'b0;
      dec.writes_rd = 1'b1;
      dec.illegal   = 1'b0;
      case (inst.r_fmt.opcode)
         bit_core_pkg::op_imm: begin
            dec.use_imm = 1'b1;
            case (f3)
               3'b000: dec.op = bit_core_pkg::op_addi;
               3'b100: dec.op = bit_core_pkg::op_xori;
               3'b111: dec.op = bit_core_pkg::op_andi;
               3'b110: dec.op = bit_core_pkg::op_ori;
               3'b001: begin
                  dec.imm = {27'd0, shamt};
                  if (f7 == bit_core_pkg::f7_rot) begin
                     // unary Zbb group, selected by rs2
                     case (shamt)
                        5'd0:    dec.op = bit_core_pkg::op_clz;
                        5'd1:    dec.op = bit_core_pkg::op_ctz;
                        5'd2:    dec.op = bit_core_pkg::op_cpop;
                        5'd4:    dec.op = bit_core_pkg::op_sext_b;
                        5'd5:    dec.op = bit_core_pkg::op_sext_h;
                        default: dec.illegal = 1'b1;
                     endcase
                  end else if (f7 == bit_core_pkg::f7_bclr) begin
                     dec.op = bit_core_pkg::op_bclri;
                  end else if (f7 == bit_core_pkg::f7_binv) begin
                     dec.op = bit_core_pkg::op_binvi;
                  end else if (f7 == bit_core_pkg::f7_bset) begin
                     dec.op = bit_core_pkg::op_bseti;
                  end else begin
                     dec.illegal = 1'b1;
                  end
               end
               3'b101: begin
                  dec.imm = {27'd0, shamt};
                  // orc.b and rev8 match on the whole imm12
                  if (inst.i_fmt.imm12 == bit_core_pkg::imm12_orc_b) begin
                     dec.op = bit_core_pkg::op_orc_b;
                  end else if (inst.i_fmt.imm12 == bit_core_pkg::imm12_rev8) begin
                     dec.op = bit_core_pkg::op_rev8;
                  end else if (f7 == bit_core_pkg::f7_rot) begin
                     dec.op = bit_core_pkg::op_rori;
                  end else if (f7 == bit_core_pkg::f7_bclr) begin
                     dec.op = bit_core_pkg::op_bexti;
                  end else begin
                     dec.illegal = 1'b1;
                  end
               end
               default: dec.illegal = 1'b1;
            endcase
         end
         bit_core_pkg::op_reg: begin
            case ({f7, f3})
               {bit_core_pkg::f7_base, 3'b000}: dec.op = bit_core_pkg::op_add;
               {bit_core_pkg::f7_base, 3'b100}: dec.op = bit_core_pkg::op_xor;
               {bit_core_pkg::f7_base, 3'b110}: dec.op = bit_core_pkg::op_or;
               {bit_core_pkg::f7_base, 3'b111}: dec.op = bit_core_pkg::op_and;
               {bit_core_pkg::f7_alt,  3'b000}: dec.op = bit_core_pkg::op_sub;
               {bit_core_pkg::f7_alt,  3'b111}: dec.op = bit_core_pkg::op_andn;
               {bit_core_pkg::f7_alt,  3'b110}: dec.op = bit_core_pkg::op_orn;
               {bit_core_pkg::f7_alt,  3'b100}: dec.op = bit_core_pkg::op_xnor;
               {bit_core_pkg::f7_zba,  3'b010}: dec.op = bit_core_pkg::op_sh1add;
               {bit_core_pkg::f7_zba,  3'b100}: dec.op = bit_core_pkg::op_sh2add;
               {bit_core_pkg::f7_zba,  3'b110}: dec.op = bit_core_pkg::op_sh3add;
               {bit_core_pkg::f7_rot,  3'b001}: dec.op = bit_core_pkg::op_rol;
               {bit_core_pkg::f7_rot,  3'b101}: dec.op = bit_core_pkg::op_ror;
               {bit_core_pkg::f7_bclr, 3'b001}: dec.op = bit_core_pkg::op_bclr;
               {bit_core_pkg::f7_bclr, 3'b101}: dec.op = bit_core_pkg::op_bext;
               {bit_core_pkg::f7_binv, 3'b001}: dec.op = bit_core_pkg::op_binv;
               {bit_core_pkg::f7_bset, 3'b001}: dec.op = bit_core_pkg::op_bset;
               {bit_core_pkg::f7_zext, 3'b100}: begin
                  // zext.h only with rs2 zero
                  if (shamt == 5'd0) dec.op = bit_core_pkg::op_zext_h;
                  else dec.illegal = 1'b1;
               end
               default: dec.illegal = 1'b1;
            endcase
         end
         bit_core_pkg::op_lui: begin
            dec.op  = bit_core_pkg::op_load_upper;
            dec.imm = {word[31:12], 12'd0};
         end
         bit_core_pkg::op_jal: begin
            dec.op  = bit_core_pkg::op_jump;
            // J immediate, bit 0 always zero
            dec.imm = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
         end
         default: dec.illegal = 1'b1;
      endcase
      // unknown encodings turn into a nop without a write
      if (dec.illegal) begin
         dec.op        = bit_core_pkg::op_nop;
         dec.writes_rd = 1'b0;
      end
   end

endmodule

// ==== hdl/line_ram.sv ====
module line_ram (
   input  logic                                clk,
   input  logic                                load_valid,
   input  bit_core_pkg::load_s                 load,
   input  logic [bit_core_pkg::line_addr_w-1:0] rd_addr,
   output logic [bit_core_pkg::line_w-1:0]      rd_line
);

   // program store, one 128-bit line per entry
   logic [bit_core_pkg::line_w-1:0] mem [bit_core_pkg::ram_lines];

   // line write from the load port
   always_ff @(posedge clk) begin
      if (load_valid) begin
         mem[load.addr] <= load.line;
      end
   end

   // registered read, line valid one cycle after the address
   always_ff @(posedge clk) begin
      rd_line <= mem[rd_addr];
   end

endmodule

// ==== hdl/reg_file.sv ====
module reg_file (
   input  logic                          clk,
   input  logic                          reset,
   input  logic [4:0]                    rs1,
   input  logic [4:0]                    rs2,
   output logic [bit_core_pkg::xlen-1:0] rs1_data,
   output logic [bit_core_pkg::xlen-1:0] rs2_data,
   input  logic                          we,
   input  logic [4:0]                    rd,
   input  logic [bit_core_pkg::xlen-1:0] rd_data
);

   logic [bit_core_pkg::xlen-1:0] regs [32];

   // x0 reads as zero whatever the array holds
   assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
   assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (we && rd != 5'd0) begin
         regs[rd] <= rd_data;
      end
   end

endmodule

// ==== tests/bit_core_props.sv ====
module bit_core_props (
   input logic clk,
   input logic reset,
   input logic retire_valid,
   input logic halted
);

   // count of failed assertions
   int fail_count = 0;

   // two-cycle instructions, so never two retires back to back
   retire_spacing: assert property (
      @(posedge clk) disable iff (reset) retire_valid |=> !retire_valid
   ) else begin
      fail_count++;
      $error("retire_valid high in two consecutive cycles");
   end

   // nothing retires once the core has stopped
   quiet_when_halted: assert property (
      @(posedge clk) disable iff (reset) halted |-> !retire_valid
   ) else begin
      fail_count++;
      $error("retire_valid high while halted");
   end

   // only a reset can clear halted
   halt_sticky: assert property (
      @(posedge clk) $fell(halted) |-> $past(reset)
   ) else begin
      fail_count++;
      $error("halted fell without reset");
   end

endmodule

bind bit_core bit_core_props u_bit_core_props (
   .clk          (clk),
   .reset        (reset),
   .retire_valid (retire_valid),
   .halted       (halted)
);

// ==== tests/bit_core_tb.sv ====
module bit_core_tb;

   // one program row with the retire it should give
   typedef struct packed {
      logic [31:0] inst;
      logic [4:0]  rd;
      logic [31:0] value;
   } row_s;

   logic                  clk;
   logic                  reset;
   logic                  load_valid;
   bit_core_pkg::load_s   load;
   logic                  run;
   logic                  retire_valid;
   bit_core_pkg::retire_s retire;
   logic                  halted;

   row_s rows[$];
   row_s exp_row;
   int   row_idx;
   int   mismatch_errors;
   int   other_errors;
   int   n_lines;

   bit_core u_bit_core (
      .clk          (clk),
      .reset        (reset),
      .load_valid   (load_valid),
      .load         (load),
      .run          (run),
      .retire_valid (retire_valid),
      .retire       (retire),
      .halted       (halted)
   );

   always #50 clk = ~clk;

   function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, bit_core_pkg::op_reg};
   endfunction

   function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
      return {imm, rs1, f3, rd, bit_core_pkg::op_imm};
   endfunction

   function automatic logic [31:0] lui_word(input logic [19:0] imm, input logic [4:0] rd);
      return {imm, rd, bit_core_pkg::op_lui};
   endfunction

   task automatic push_row(input logic [31:0] w, input logic [4:0] rd, input logic [31:0] v);
      row_s r;
      r.inst  = w;
      r.rd    = rd;
      r.value = v;
      rows.push_back(r);
   endtask

   // expected values worked out by hand, x1 = 12345678 after row 1
   task automatic fill_program();
      push_row(lui_word(20'h12345, 5'd1), 5'd1, 32'h1234_5000);
      push_row(i_word(12'h678, 5'd1, 3'b000, 5'd1), 5'd1, 32'h1234_5678);
      push_row(i_word(12'hfff, 5'd0, 3'b000, 5'd2), 5'd2, 32'hffff_ffff);
      push_row(i_word(12'h0ff, 5'd1, 3'b100, 5'd3), 5'd3, 32'h1234_5687);
      push_row(r_word(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd4), 5'd4, 32'h1234_5677);
      push_row(r_word(7'b0100000, 5'd2, 5'd1, 3'b000, 5'd5), 5'd5, 32'h1234_5679);
      push_row(r_word(7'b0000000, 5'd2, 5'd1, 3'b100, 5'd6), 5'd6, 32'hedcb_a987);
      // writes to x0 report zero
      push_row(i_word(12'h005, 5'd1, 3'b000, 5'd0), 5'd0, 32'h0);
      push_row(r_word(7'b0000000, 5'd1, 5'd1, 3'b000, 5'd0), 5'd0, 32'h0);
      push_row(i_word(12'h0f0, 5'd1, 3'b111, 5'd7), 5'd7, 32'h0000_0070);
      push_row(i_word(12'h123, 5'd0, 3'b110, 5'd8), 5'd8, 32'h0000_0123);
      // unary Zbb, clz and ctz of x0 give 32
      push_row(i_word(12'h600, 5'd1, 3'b001, 5'd9), 5'd9, 32'd3);
      push_row(i_word(12'h601, 5'd1, 3'b001, 5'd10), 5'd10, 32'd3);
      push_row(i_word(12'h602, 5'd1, 3'b001, 5'd11), 5'd11, 32'd13);
      push_row(i_word(12'h600, 5'd0, 3'b001, 5'd12), 5'd12, 32'd32);
      push_row(i_word(12'h601, 5'd0, 3'b001, 5'd13), 5'd13, 32'd32);
      push_row(i_word(12'h604, 5'd6, 3'b001, 5'd14), 5'd14, 32'hffff_ff87);
      push_row(i_word(12'h605, 5'd6, 3'b001, 5'd15), 5'd15, 32'hffff_a987);
      push_row(r_word(7'b0000100, 5'd0, 5'd2, 3'b100, 5'd16), 5'd16, 32'h0000_ffff);
      push_row(i_word(12'h698, 5'd1, 3'b101, 5'd17), 5'd17, 32'h7856_3412);
      push_row(i_word(12'h287, 5'd8, 3'b101, 5'd18), 5'd18, 32'h0000_ffff);
      // bit indices 4 and 31
      push_row(i_word(12'd4, 5'd0, 3'b000, 5'd19), 5'd19, 32'd4);
      push_row(i_word(12'd31, 5'd0, 3'b000, 5'd20), 5'd20, 32'd31);
      push_row(r_word(7'b0110000, 5'd19, 5'd1, 3'b001, 5'd21), 5'd21, 32'h2345_6781);
      push_row(r_word(7'b0110000, 5'd19, 5'd1, 3'b101, 5'd22), 5'd22, 32'h8123_4567);
      push_row(i_word({7'b0110000, 5'd31}, 5'd1, 3'b101, 5'd23), 5'd23, 32'h2468_acf0);
      push_row(r_word(7'b0110000, 5'd20, 5'd1, 3'b001, 5'd24), 5'd24, 32'h091a_2b3c);
      push_row(r_word(7'b0100100, 5'd19, 5'd1, 3'b001, 5'd25), 5'd25, 32'h1234_5668);
      push_row(i_word({7'b0100100, 5'd31}, 5'd2, 3'b001, 5'd26), 5'd26, 32'h7fff_ffff);
      push_row(r_word(7'b0100100, 5'd19, 5'd1, 3'b101, 5'd27), 5'd27, 32'd1);
      push_row(i_word({7'b0100100, 5'd31}, 5'd6, 3'b101, 5'd28), 5'd28, 32'd1);
      push_row(r_word(7'b0110100, 5'd20, 5'd1, 3'b001, 5'd29), 5'd29, 32'h9234_5678);
      push_row(i_word({7'b0110100, 5'd4}, 5'd1, 3'b001, 5'd30), 5'd30, 32'h1234_5668);
      push_row(r_word(7'b0010100, 5'd20, 5'd1, 3'b001, 5'd31), 5'd31, 32'h9234_5678);
      push_row(i_word({7'b0010100, 5'd4}, 5'd0, 3'b001, 5'd25), 5'd25, 32'h0000_0010);
      // Zba and inverted logic
      push_row(r_word(7'b0010000, 5'd1, 5'd19, 3'b010, 5'd26), 5'd26, 32'h1234_5680);
      push_row(r_word(7'b0010000, 5'd1, 5'd19, 3'b100, 5'd27), 5'd27, 32'h1234_5688);
      push_row(r_word(7'b0010000, 5'd1, 5'd19, 3'b110, 5'd28), 5'd28, 32'h1234_5698);
      push_row(r_word(7'b0100000, 5'd8, 5'd1, 3'b111, 5'd29), 5'd29, 32'h1234_5658);
      push_row(r_word(7'b0100000, 5'd8, 5'd0, 3'b110, 5'd30), 5'd30, 32'hffff_fedc);
      push_row(r_word(7'b0100000, 5'd8, 5'd1, 3'b100, 5'd31), 5'd31, 32'hedcb_a8a4);
      // jal x0, 0 stops the core
      push_row(32'h0000_006f, 5'd0, 32'h0);
   endtask

   // four rows per line, word 0 in the low bits, zero past the end
   function automatic logic [127:0] line_of(input int l);
      logic [127:0] ln;
      ln = '0;
      for (int k = 0; k < 4; k++) begin
         if (4 * l + k < rows.size()) ln[k*32 +: 32] = rows[4*l+k].inst;
      end
      return ln;
   endfunction

   // outputs sampled mid-cycle, away from the driving edge
   always @(negedge clk) begin
      if (!reset && !run) begin
         assert (retire_valid === 1'b0 && halted === 1'b0) else begin
            other_errors++;
            $display("retire_valid or halted active before run at time %0t", $time);
         end
      end
      if (!reset && retire_valid === 1'b1) begin
         assert (row_idx < rows.size()) else begin
            other_errors++;
            $display("unexpected retire after the last program row at time %0t", $time);
         end
         if (row_idx < rows.size()) begin
            exp_row = rows[row_idx];
            assert (retire.pc === 32'(row_idx * 4)) else begin
               mismatch_errors++;
               $display("MISMATCH time %0t retire.pc expected %h actual %h",
                        $time, 32'(row_idx * 4), retire.pc);
            end
            assert (retire.rd === exp_row.rd) else begin
               mismatch_errors++;
               $display("MISMATCH time %0t retire.rd expected %0d actual %0d",
                        $time, exp_row.rd, retire.rd);
            end
            assert (retire.value === exp_row.value) else begin
               mismatch_errors++;
               $display("MISMATCH time %0t retire.value expected %h actual %h",
                        $time, exp_row.value, retire.value);
            end
         end
         row_idx++;
      end
   end

   // limit covers load, idle gap, two cycles per row and slack
   initial begin
      @(negedge reset);
      repeat (n_lines + 16 + rows.size() * 2 + 64) @(posedge clk);
      $display("timeout: program did not halt, %0d of %0d rows retired",
               row_idx, rows.size());
      $display("summary: %0d value mismatches, %0d other errors, %0d property failures",
               mismatch_errors, other_errors, u_bit_core.u_bit_core_props.fail_count);
      $display("ERRORS FOUND");
      $finish;
   end

   initial begin
      clk             = 1'b0;
      reset           = 1'b1;
      load_valid      = 1'b0;
      load            = '0;
      run             = 1'b0;
      row_idx         = 0;
      mismatch_errors = 0;
      other_errors    = 0;
      fill_program();
      n_lines = (rows.size() + 3) / 4;
      repeat (16) @(posedge clk);
      reset <= 1'b0;
      // one line per cycle, no back-pressure
      for (int l = 0; l < n_lines; l++) begin
         @(posedge clk);
         load_valid <= 1'b1;
         load.addr  <= l[bit_core_pkg::line_addr_w-1:0];
         load.line  <= line_of(l);
      end
      @(posedge clk);
      load_valid <= 1'b0;
      load       <= '0;
      // idle a few cycles before starting
      repeat (4) @(posedge clk);
      run <= 1'b1;
      wait (halted === 1'b1);
      // any retire here is flagged by the checker
      repeat (32) @(posedge clk);
      assert (row_idx == rows.size()) else begin
         other_errors++;
         $display("core halted after %0d retires, %0d expected", row_idx, rows.size());
      end
      $display("summary: %0d value mismatches, %0d other errors, %0d property failures",
               mismatch_errors, other_errors, u_bit_core.u_bit_core_props.fail_count);
      if (mismatch_errors + other_errors + u_bit_core.u_bit_core_props.fail_count == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule
